//--- common/decode_defs.svh
// Decode stage width macros
// Fixed by the MIPS-style ISA, shared by RTL and testbench

`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Data, PC and instruction word
`define DATA_WIDTH 32

// Register index, as in the rs/rt/rd fields
`define REG_ADDR_WIDTH 5

// Architectural register count
`define NUM_REGS 32

`endif

//--- common/decodePkg.sv
// Decode stage types
// Opcode encoding, control bits, write-back port and decode/execute register

`default_nettype none

`include "decode_defs.svh"

package decodePkg;

    // Primary opcode, instruction bits 31..26
    typedef enum logic [5:0] {
        opSpecial = 6'b000000, // R-type, funct selects the operation
        opRegimm  = 6'b000001, // BLTZ/BGEZ selected by rt
        opJ       = 6'b000010,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opBlez    = 6'b000110,
        opBgtz    = 6'b000111,
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opOri     = 6'b001101,
        opLui     = 6'b001111,
        opLw      = 6'b100011,
        opSw      = 6'b101011
    } opcode_e;

    // One-hot class bits plus side effects
    typedef struct packed {
        logic regWe;   // Writes rd/rt at write-back
        logic iType;
        logic rType;
        logic jType;   // Jumps and branches
        logic memWe;   // Store
        logic memWb;   // Load result goes back to a register
        logic illegal;
    } ctrl_t;

    // Write port, driven by the write-back stage
    typedef struct packed {
        logic                       writeEnable;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     data;
    } regWrite_t;

    // Decode/execute register, operands travel separately
    typedef struct packed {
        logic [`DATA_WIDTH-1:0]     pc;
        logic [`DATA_WIDTH-1:0]     ir;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        ctrl_t                      ctrl;
    } idEx_t;

endpackage

`default_nettype wire

//--- decode/regFile.sv
// Register file for the decode stage
// Two registered read ports, one write port, r0 hard-wired to zero,
// and write-to-read bypass on the same edge

`default_nettype none
`timescale 1ns/10ps

`include "decode_defs.svh"

module regFile import decodePkg::*; (
    input  wire logic                       clock,
    input  wire logic                       arstN,
    input  wire logic [`REG_ADDR_WIDTH-1:0] rsAddr,
    input  wire logic [`REG_ADDR_WIDTH-1:0] rtAddr,
    input  wire regWrite_t                  writeBack,
    output logic      [`DATA_WIDTH-1:0]     rsData,
    output logic      [`DATA_WIDTH-1:0]     rtData
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    // Value a read port captures this edge
    function automatic logic [`DATA_WIDTH-1:0] readPort(
        input logic [`REG_ADDR_WIDTH-1:0] addr
    );
        logic [`DATA_WIDTH-1:0] value;
        if (addr == '0)
            value = '0;                 // r0 always zero
        else if (writeBack.writeEnable && writeBack.rd == addr)
            value = writeBack.data;     // Bypass the write in flight
        else
            value = regs[addr];
        return value;
    endfunction

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
            rsData <= '0;
            rtData <= '0;
        end
        else
        begin
            // Writes to r0 are dropped
            if (writeBack.writeEnable && writeBack.rd != '0)
                regs[writeBack.rd] <= writeBack.data;
            rsData <= readPort(rsAddr);
            rtData <= readPort(rtAddr);
        end
    end

endmodule

`default_nettype wire

//--- decode/controlDecoder.sv
// Control decoder
// Maps the primary opcode, and rt for REGIMM, onto the control bits.
// Purely combinational

`default_nettype none
`timescale 1ns/10ps

`include "decode_defs.svh"

module controlDecoder import decodePkg::*; (
    input  wire opcode_e                    opcode,
    input  wire logic [`REG_ADDR_WIDTH-1:0] rt,
    input  wire logic                       insnValid,
    input  wire logic [`DATA_WIDTH-1:0]     insn,
    output ctrl_t                           ctrl
);

    logic isNop;

    // Bubble or all-zero word, nothing to do
    assign isNop = !insnValid || (insn == '0);

    always_comb
    begin
        ctrl = '0;
        if (!isNop)
        begin
            case (opcode)
                opSpecial:
                begin
                    ctrl.rType = 1'b1;
                    ctrl.regWe = 1'b1;
                end

                // Immediate ALU ops
                opAddiu, opSlti, opOri, opLui:
                begin
                    ctrl.iType = 1'b1;
                    ctrl.regWe = 1'b1;
                end

                opLw:
                begin
                    ctrl.iType = 1'b1;
                    ctrl.regWe = 1'b1;
                    ctrl.memWb = 1'b1;  // Result from memory
                end

                opSw:
                begin
                    ctrl.iType = 1'b1;
                    ctrl.memWe = 1'b1;
                end

                // Jump and branches write no register
                opJ, opBeq, opBne, opBlez, opBgtz:
                begin
                    ctrl.jType = 1'b1;
                end

                opRegimm:
                begin
                    // Only BLTZ (rt 0) and BGEZ (rt 1)
                    if (rt == 5'd0 || rt == 5'd1)
                        ctrl.jType = 1'b1;
                    else
                        ctrl.illegal = 1'b1;
                end

                default:
                begin
                    ctrl.illegal = 1'b1;    // Unlisted opcode
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- decode/decodeStage.sv
// Instruction decode stage
// Splits the instruction into fields, reads rs/rt from the register file,
// decodes control and loads the decode/execute register every cycle

`default_nettype none
`timescale 1ns/10ps

`include "decode_defs.svh"

module decodeStage import decodePkg::*; (
    input  wire logic                   clock,
    input  wire logic                   arstN,
    input  wire logic [`DATA_WIDTH-1:0] insn,
    input  wire logic [`DATA_WIDTH-1:0] pc,
    input  wire logic                   insnValid,
    input  wire regWrite_t              writeBack,
    output idEx_t                       idEx,
    output logic      [`DATA_WIDTH-1:0] rsData,
    output logic      [`DATA_WIDTH-1:0] rtData
);

    // Instruction fields
    opcode_e                    opcode;
    logic [`REG_ADDR_WIDTH-1:0] rsField;
    logic [`REG_ADDR_WIDTH-1:0] rtField;
    logic [`REG_ADDR_WIDTH-1:0] rdField;

    ctrl_t decodedCtrl;

    assign opcode  = opcode_e'(insn[31:26]);
    assign rsField = insn[25:21];
    assign rtField = insn[20:16];
    assign rdField = insn[15:11];

    // Read data is registered inside, lines up with idEx
    regFile i_regFile (
        .clock     (clock),
        .arstN     (arstN),
        .rsAddr    (rsField),
        .rtAddr    (rtField),
        .writeBack (writeBack),
        .rsData    (rsData),
        .rtData    (rtData)
    );

    controlDecoder i_controlDecoder (
        .opcode    (opcode),
        .rt        (rtField),
        .insnValid (insnValid),
        .insn      (insn),
        .ctrl      (decodedCtrl)
    );

    // Decode/execute register
    // Loaded every cycle, a bubble shows up as zero control
    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            idEx <= '0;
        end
        else
        begin
            idEx.pc   <= pc;
            idEx.ir   <= insn;
            idEx.rd   <= rdField;
            idEx.ctrl <= decodedCtrl;
        end
    end

endmodule

`default_nettype wire

//--- test/tbDecodeStage.sv
// Testbench for the decode stage
// Random instructions and write-backs from a fixed seed, checked against
// a register and control model one edge later

`default_nettype none
`timescale 1ns/10ps

`include "decode_defs.svh"

module tbDecodeStage import decodePkg::*; ();

    localparam int NUM_CYCLES    = 2000;
    localparam int RESET_TIMEOUT = 20;      // Cycles

    // Opcodes the stage supports
    localparam logic [5:0] LEGAL_OPS [13] = '{
        opSpecial, opRegimm, opJ, opBeq, opBne, opBlez, opBgtz,
        opAddiu, opSlti, opOri, opLui, opLw, opSw
    };

    logic                   clock;
    logic                   arstN;
    logic [`DATA_WIDTH-1:0] insn;
    logic [`DATA_WIDTH-1:0] pc;
    logic                   insnValid;
    regWrite_t              writeBack;
    idEx_t                  idEx;
    logic [`DATA_WIDTH-1:0] rsData;
    logic [`DATA_WIDTH-1:0] rtData;

    integer seed = 32'h9d7a;

    // Model state
    logic [`DATA_WIDTH-1:0]     modelRegs [`NUM_REGS];
    logic [`DATA_WIDTH-1:0]     expPc;
    logic [`DATA_WIDTH-1:0]     expIr;
    logic [`REG_ADDR_WIDTH-1:0] expRd;
    logic [6:0]                 expCtrl;
    logic [`DATA_WIDTH-1:0]     expRs;
    logic [`DATA_WIDTH-1:0]     expRt;

    int checkCount  = 0;
    int errorCount  = 0;
    int illegalHits = 0;
    int bypassHits  = 0;

    decodeStage i_decodeStage (
        .clock     (clock),
        .arstN     (arstN),
        .insn      (insn),
        .pc        (pc),
        .insnValid (insnValid),
        .writeBack (writeBack),
        .idEx      (idEx),
        .rsData    (rsData),
        .rtData    (rtData)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial
    begin
        arstN = 1'b0;
        repeat (4) @(posedge clock);
        #5 arstN = 1'b1;    // Away from the sampling point
    end

    // Uniform value in 0..n-1
    function automatic int randBelow(input int n);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return r % n;
    endfunction

    // Control bits in order regWe iType rType jType memWe memWb illegal
    function automatic logic [6:0] modelCtrl(input logic [31:0] word, input logic valid);
        logic [6:0] bits;
        bits = 7'b0000000;
        if (valid && word != 32'h0)
        begin
            case (word[31:26])
                opSpecial:                     bits = 7'b1010000;
                opAddiu, opSlti, opOri, opLui: bits = 7'b1100000;
                opLw:                          bits = 7'b1100010;
                opSw:                          bits = 7'b0100100;
                opJ, opBeq, opBne, opBlez, opBgtz:
                    bits = 7'b0001000;
                opRegimm:
                    bits = (word[20:16] <= 5'd1) ? 7'b0001000 : 7'b0000001;
                default:                       bits = 7'b0000001;
            endcase
        end
        return bits;
    endfunction

    // Register read as seen at the coming edge, with bypass
    function automatic logic [31:0] modelRead(input logic [4:0] addr);
        if (addr == 5'd0)
            return 32'h0;
        if (writeBack.writeEnable && writeBack.rd == addr)
            return writeBack.data;
        return modelRegs[addr];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compareOutputs();
        checkValue("idEx.pc", expPc, idEx.pc);
        checkValue("idEx.ir", expIr, idEx.ir);
        checkValue("idEx.rd", 32'(expRd), 32'(idEx.rd));
        checkValue("idEx.ctrl", 32'(expCtrl), 32'(idEx.ctrl));
        checkValue("rsData", expRs, rsData);
        checkValue("rtData", expRt, rtData);
    endtask

    task automatic driveRandom();
        logic [31:0] word;
        word = $random(seed);
        if (randBelow(100) < 85)
            word[31:26] = LEGAL_OPS[randBelow(13)];
        else
            word[31:26] = 6'($random(seed));
        // Half the REGIMM words get BLTZ or BGEZ
        if (word[31:26] == opRegimm && randBelow(2) == 0)
            word[20:16] = 5'(randBelow(2));
        if (randBelow(100) < 5)
            word = 32'h0;   // NOP
        insn      = word;
        pc        = $random(seed);
        insnValid = (randBelow(100) < 80);
        writeBack.writeEnable = (randBelow(2) == 1);
        writeBack.rd          = 5'($random(seed));
        if (randBelow(4) == 0)
            writeBack.rd = word[25:21];     // Aim at rs to hit the bypass
        writeBack.data = $random(seed);
    endtask

    // Expected outputs after the next edge, then commit the write
    task automatic predictOutputs();
        expPc   = pc;
        expIr   = insn;
        expRd   = insn[15:11];
        expCtrl = modelCtrl(insn, insnValid);
        expRs   = modelRead(insn[25:21]);
        expRt   = modelRead(insn[20:16]);
        if (expCtrl[0])
            illegalHits++;
        if (writeBack.writeEnable && writeBack.rd != 5'd0)
        begin
            if (writeBack.rd == insn[25:21] || writeBack.rd == insn[20:16])
                bypassHits++;
            modelRegs[writeBack.rd] = writeBack.data;
        end
    endtask

    initial
    begin
        int waitCycles;
        insn      = '0;
        pc        = '0;
        insnValid = 1'b0;
        writeBack = '0;
        for (int i = 0; i < `NUM_REGS; i++)
            modelRegs[i] = '0;
        expPc   = '0;
        expIr   = '0;
        expRd   = '0;
        expCtrl = '0;
        expRs   = '0;
        expRt   = '0;

        // Random inputs in reset, none of them may reach the outputs or the registers
        waitCycles = 0;
        while (arstN !== 1'b1 && waitCycles < RESET_TIMEOUT)
        begin
            driveRandom();
            @(posedge clock);
            #1;
            if (arstN !== 1'b1)
                compareOutputs();   // Edge was in reset, all zero
            waitCycles++;
        end

        if (arstN !== 1'b1)
        begin
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
        else
        begin
            // First edge after release loaded the last stimulus from reset
            predictOutputs();
            compareOutputs();
            for (int cycle = 0; cycle < NUM_CYCLES; cycle++)
            begin
                driveRandom();
                predictOutputs();
                @(posedge clock);
                #1;
                compareOutputs();
            end
            $display("Checks %0d, errors %0d, illegal decodes %0d, bypassed writes %0d",
                     checkCount, errorCount, illegalHits, bypassHits);
            if (errorCount == 0)
                $display("** PASS **");
            else
                $display("** FAIL **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
common/decodePkg.sv
decode/regFile.sv
decode/controlDecoder.sv
decode/decodeStage.sv
test/tbDecodeStage.sv

//--- Makefile
# Verilator flow for the decode stage

VERILATOR ?= verilator
FILELIST  ?= build.f
RTL_TOP   ?= decodeStage
TB_TOP    ?= tbDecodeStage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= ** PASS **

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) && echo "Simulation passed" || \
		{ echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
